// ==== hw/rv32i_pkg.sv ====
package rv32i_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;

  // base integer opcodes
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_f3_e;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_f3_e;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_f3_e;

  // add, sll, xor, srl, or and and line up with funct3
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_op_e;

  typedef struct packed {
    opcode_e  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    i_imm;
    word_t    s_imm;
    word_t    b_imm;
    word_t    u_imm;
    word_t    j_imm;
  } decoded_instr_t;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;

  // split a raw word into fields and sign-extended immediates
  function automatic decoded_instr_t decode(word_t raw);
    decoded_instr_t d;
    d.opcode = opcode_e'(raw[6:0]);
    d.funct3 = raw[14:12];
    d.funct7 = raw[31:25];
    d.rs1    = raw[19:15];
    d.rs2    = raw[24:20];
    d.rd     = raw[11:7];
    d.i_imm  = {{21{raw[31]}}, raw[30:20]};
    d.s_imm  = {{21{raw[31]}}, raw[30:25], raw[11:7]};
    d.b_imm  = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
    d.u_imm  = {raw[31:12], 12'h000};
    d.j_imm  = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
    return d;
  endfunction

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

  typedef enum logic {a_rs1, a_pc} alu_a_sel_e;

  typedef enum logic [2:0] {
    b_rs2, b_i_imm, b_u_imm, b_b_imm, b_s_imm, b_j_imm
  } alu_b_sel_e;

  typedef enum logic {cmp_b_rs2, cmp_b_i_imm} cmp_b_sel_e;

  // branch codes, with slt and sltu in the two free slots
  typedef enum logic [2:0] {
    cmp_beq  = rv32i_pkg::beq,
    cmp_bne  = rv32i_pkg::bne,
    cmp_slt  = 3'b010,
    cmp_sltu = 3'b011,
    cmp_blt  = rv32i_pkg::blt,
    cmp_bge  = rv32i_pkg::bge,
    cmp_bltu = rv32i_pkg::bltu,
    cmp_bgeu = rv32i_pkg::bgeu
  } cmp_op_e;

  typedef enum logic [2:0] {wb_alu, wb_cmp, wb_u_imm, wb_load, wb_pc4} wb_sel_e;

  typedef enum logic [1:0] {flow_none, flow_cond, flow_jump} flow_e;

  // all-zero word is a bubble
  typedef struct packed {
    alu_a_sel_e         alu_a_sel;
    alu_b_sel_e         alu_b_sel;
    cmp_b_sel_e         cmp_b_sel;
    rv32i_pkg::alu_op_e alu_op;
    cmp_op_e            cmp_op;
    wb_sel_e            wb_sel;
    flow_e              flow;
    logic               mem_read;
    logic               mem_write;
    logic               reg_write;
  } ctrl_word_t;

  typedef struct packed {
    rv32i_pkg::word_t          pc;
    rv32i_pkg::decoded_instr_t instr;
  } if_id_t;

  typedef struct packed {
    rv32i_pkg::word_t          pc;
    rv32i_pkg::decoded_instr_t instr;
    rv32i_pkg::word_t          rs1_data;
    rv32i_pkg::word_t          rs2_data;
    ctrl_word_t                ctrl;
  } id_ex_t;

  typedef struct packed {
    rv32i_pkg::word_t          pc;
    rv32i_pkg::decoded_instr_t instr;
    ctrl_word_t                ctrl;
    rv32i_pkg::word_t          alu;
    rv32i_pkg::word_t          rs2_data;
    logic                      cmp;
  } ex_mem_t;

  typedef struct packed {
    rv32i_pkg::word_t          pc;
    rv32i_pkg::decoded_instr_t instr;
    ctrl_word_t                ctrl;
    rv32i_pkg::word_t          alu;
    rv32i_pkg::word_t          load_data;
    logic                      cmp;
  } mem_wb_t;

  typedef struct packed {
    logic             go;
    rv32i_pkg::word_t target;
  } redirect_t;

  typedef struct packed {
    logic                we;
    rv32i_pkg::reg_idx_t rd;
    rv32i_pkg::word_t    data;
  } rf_write_t;

  typedef struct packed {
    logic                read;
    logic                write;
    rv32i_pkg::byte_en_t mbe;
    rv32i_pkg::word_t    address;
    rv32i_pkg::word_t    wdata;
  } dmem_req_t;

endpackage

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter rv32i_pkg::word_t reset_pc = '0
) (
  input  logic                clk,
  input  logic                reset,
  input  rv32i_pkg::word_t    icache_rdata,
  input  logic                icache_resp,
  input  logic                mem_busy,
  input  pipe_pkg::redirect_t redirect,
  output logic                icache_read,
  output rv32i_pkg::word_t    icache_address,
  output logic                stall,
  output pipe_pkg::if_id_t    if_id
);

  rv32i_pkg::word_t pc;
  rv32i_pkg::word_t next_pc;
  pipe_pkg::if_id_t bubble;

  // whole pipeline freezes until both ports have answered
  assign stall = ~icache_resp | mem_busy;

  assign next_pc = redirect.go ? redirect.target : pc + 32'd4;

  // no fetch while held in reset
  assign icache_read    = ~reset;
  assign icache_address = pc;

  assign bubble = '{pc: '0, instr: rv32i_pkg::decode(rv32i_pkg::nop_instr)};

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= reset_pc;
      if_id <= bubble;
    end else if (!stall) begin
      pc <= next_pc;
      // the word fetched alongside a redirect is off the taken path
      if (redirect.go) begin
        if_id <= bubble;
      end else begin
        if_id <= '{pc: pc, instr: rv32i_pkg::decode(icache_rdata)};
      end
    end
  end

  // redirect targets arrive from execute with the low bits cleared
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic                clk,
  input  logic                reset,
  input  rv32i_pkg::reg_idx_t rs1_idx,
  input  rv32i_pkg::reg_idx_t rs2_idx,
  input  pipe_pkg::rf_write_t write,
  output rv32i_pkg::word_t    rs1_data,
  output rv32i_pkg::word_t    rs2_data
);

  rv32i_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write.we && write.rd != '0) begin
      regs[write.rd] <= write.data;
    end
  end

  // plain array reads, a same-cycle write is not seen
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== hw/ctrl_decoder.sv ====
`timescale 1ns/1ps

module ctrl_decoder (
  input  rv32i_pkg::decoded_instr_t instr,
  output pipe_pkg::ctrl_word_t      ctrl
);

  // zero word already selects rs1, rs2, add and alu writeback
  always_comb begin
    ctrl = '0;
    case (instr.opcode)
      rv32i_pkg::op_lui: begin
        ctrl.wb_sel    = pipe_pkg::wb_u_imm;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::op_auipc: begin
        ctrl.alu_a_sel = pipe_pkg::a_pc;
        ctrl.alu_b_sel = pipe_pkg::b_u_imm;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::op_jal: begin
        ctrl.alu_a_sel = pipe_pkg::a_pc;
        ctrl.alu_b_sel = pipe_pkg::b_j_imm;
        ctrl.flow      = pipe_pkg::flow_jump;
        ctrl.wb_sel    = pipe_pkg::wb_pc4;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::op_jalr: begin
        ctrl.alu_b_sel = pipe_pkg::b_i_imm;
        ctrl.flow      = pipe_pkg::flow_jump;
        ctrl.wb_sel    = pipe_pkg::wb_pc4;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::op_br: begin
        // alu forms the target, comparator decides
        ctrl.alu_a_sel = pipe_pkg::a_pc;
        ctrl.alu_b_sel = pipe_pkg::b_b_imm;
        ctrl.cmp_op    = pipe_pkg::cmp_op_e'(instr.funct3);
        ctrl.flow      = pipe_pkg::flow_cond;
      end
      rv32i_pkg::op_load: begin
        ctrl.alu_b_sel = pipe_pkg::b_i_imm;
        ctrl.mem_read  = 1'b1;
        ctrl.wb_sel    = pipe_pkg::wb_load;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::op_store: begin
        ctrl.alu_b_sel = pipe_pkg::b_s_imm;
        ctrl.mem_write = 1'b1;
      end
      rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
        ctrl.alu_op    = rv32i_pkg::alu_op_e'(instr.funct3);
        ctrl.cmp_op    = pipe_pkg::cmp_op_e'(instr.funct3);
        ctrl.reg_write = 1'b1;
        if (instr.opcode == rv32i_pkg::op_imm) begin
          ctrl.alu_b_sel = pipe_pkg::b_i_imm;
          ctrl.cmp_b_sel = pipe_pkg::cmp_b_i_imm;
        end
        // funct7 bit 5 picks sra, and sub on register ops only
        if (instr.funct3 == 3'b101 && instr.funct7[5]) begin
          ctrl.alu_op = rv32i_pkg::alu_sra;
        end
        if (instr.funct3 == 3'b000 && instr.funct7[5] && instr.opcode == rv32i_pkg::op_reg) begin
          ctrl.alu_op = rv32i_pkg::alu_sub;
        end
        // slt and sltu take the comparator bit
        if (instr.funct3 == 3'b010 || instr.funct3 == 3'b011) begin
          ctrl.wb_sel = pipe_pkg::wb_cmp;
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,
  input  pipe_pkg::if_id_t     if_id,
  input  rv32i_pkg::word_t     rs1_data,
  input  rv32i_pkg::word_t     rs2_data,
  input  pipe_pkg::ctrl_word_t ctrl,
  output pipe_pkg::ex_mem_t    ex_mem,
  output pipe_pkg::redirect_t  redirect
);

  pipe_pkg::id_ex_t          id_ex;
  rv32i_pkg::decoded_instr_t nop_decoded;
  rv32i_pkg::word_t          alu_a;
  rv32i_pkg::word_t          alu_b;
  rv32i_pkg::word_t          cmp_b;
  rv32i_pkg::word_t          alu_out;
  logic                      cmp_out;

  assign nop_decoded = rv32i_pkg::decode(rv32i_pkg::nop_instr);

  // **************************************************
  // operand muxes
  // **************************************************

  always_comb begin
    alu_a = (id_ex.ctrl.alu_a_sel == pipe_pkg::a_pc) ? id_ex.pc : id_ex.rs1_data;
    cmp_b = (id_ex.ctrl.cmp_b_sel == pipe_pkg::cmp_b_i_imm) ? id_ex.instr.i_imm : id_ex.rs2_data;
    case (id_ex.ctrl.alu_b_sel)
      pipe_pkg::b_i_imm: alu_b = id_ex.instr.i_imm;
      pipe_pkg::b_u_imm: alu_b = id_ex.instr.u_imm;
      pipe_pkg::b_b_imm: alu_b = id_ex.instr.b_imm;
      pipe_pkg::b_s_imm: alu_b = id_ex.instr.s_imm;
      pipe_pkg::b_j_imm: alu_b = id_ex.instr.j_imm;
      default:           alu_b = id_ex.rs2_data;
    endcase
  end

  // **************************************************
  // alu and comparator
  // **************************************************

  always_comb begin
    unique case (id_ex.ctrl.alu_op)
      rv32i_pkg::alu_add: alu_out = alu_a + alu_b;
      rv32i_pkg::alu_sll: alu_out = alu_a << alu_b[4:0];
      rv32i_pkg::alu_sra: alu_out = rv32i_pkg::word_t'($signed(alu_a) >>> alu_b[4:0]);
      rv32i_pkg::alu_sub: alu_out = alu_a - alu_b;
      rv32i_pkg::alu_xor: alu_out = alu_a ^ alu_b;
      rv32i_pkg::alu_srl: alu_out = alu_a >> alu_b[4:0];
      rv32i_pkg::alu_or:  alu_out = alu_a | alu_b;
      rv32i_pkg::alu_and: alu_out = alu_a & alu_b;
    endcase
  end

  always_comb begin
    unique case (id_ex.ctrl.cmp_op)
      pipe_pkg::cmp_beq:  cmp_out = id_ex.rs1_data == cmp_b;
      pipe_pkg::cmp_bne:  cmp_out = id_ex.rs1_data != cmp_b;
      pipe_pkg::cmp_blt,
      pipe_pkg::cmp_slt:  cmp_out = $signed(id_ex.rs1_data) < $signed(cmp_b);
      pipe_pkg::cmp_bge:  cmp_out = $signed(id_ex.rs1_data) >= $signed(cmp_b);
      pipe_pkg::cmp_bltu,
      pipe_pkg::cmp_sltu: cmp_out = id_ex.rs1_data < cmp_b;
      pipe_pkg::cmp_bgeu: cmp_out = id_ex.rs1_data >= cmp_b;
    endcase
  end

  // resolved from the instruction now in memory stage
  assign redirect.go = (ex_mem.ctrl.flow == pipe_pkg::flow_jump) ||
                       (ex_mem.ctrl.flow == pipe_pkg::flow_cond && ex_mem.cmp);
  assign redirect.target = {ex_mem.alu[31:2], 2'b00};

  // **************************************************
  // ID/EX and EX/MEM registers
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset || (!stall && redirect.go)) begin
      // on a redirect nothing younger than the branch moves on
      id_ex  <= '{pc: '0, instr: nop_decoded, rs1_data: '0, rs2_data: '0, ctrl: '0};
      ex_mem <= '{pc: '0, instr: nop_decoded, ctrl: '0, alu: '0, rs2_data: '0, cmp: 1'b0};
    end else if (!stall) begin
      id_ex  <= '{pc: if_id.pc, instr: if_id.instr, rs1_data: rs1_data,
                  rs2_data: rs2_data, ctrl: ctrl};
      ex_mem <= '{pc: id_ex.pc, instr: id_ex.instr, ctrl: id_ex.ctrl, alu: alu_out,
                  rs2_data: id_ex.rs2_data, cmp: cmp_out};
    end
  end

endmodule

// ==== hw/memory_writeback.sv ====
`timescale 1ns/1ps

module memory_writeback (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  pipe_pkg::ex_mem_t   ex_mem,
  input  rv32i_pkg::word_t    dcache_rdata,
  input  logic                dcache_resp,
  output pipe_pkg::dmem_req_t dmem_req,
  output logic                mem_busy,
  output pipe_pkg::rf_write_t rf_write
);

  pipe_pkg::mem_wb_t   mem_wb;
  logic [1:0]          offset;
  rv32i_pkg::word_t    shifted_rdata;
  rv32i_pkg::word_t    load_data;
  rv32i_pkg::byte_en_t mbe;
  logic                store_done;

  assign offset = ex_mem.alu[1:0];

  // **************************************************
  // data port
  // **************************************************

  always_comb begin
    case (rv32i_pkg::store_f3_e'(ex_mem.instr.funct3))
      rv32i_pkg::sb: mbe = 4'b0001 << offset;
      rv32i_pkg::sh: mbe = 4'b0011 << offset;
      default:       mbe = 4'b1111;
    endcase
  end

  // a store answered during a fetch stall must not be sent again
  always_ff @(posedge clk) begin
    if (reset || !stall) begin
      store_done <= 1'b0;
    end else if (dmem_req.write && dcache_resp) begin
      store_done <= 1'b1;
    end
  end

  assign dmem_req.read    = ex_mem.ctrl.mem_read;
  assign dmem_req.write   = ex_mem.ctrl.mem_write & ~store_done;
  assign dmem_req.mbe     = mbe;
  assign dmem_req.address = {ex_mem.alu[31:2], 2'b00};
  assign dmem_req.wdata   = ex_mem.rs2_data << {offset, 3'b000};

  assign mem_busy = (dmem_req.read | dmem_req.write) & ~dcache_resp;

  // addressed byte or half moved down to bit 0
  assign shifted_rdata = dcache_rdata >> {offset, 3'b000};

  always_comb begin
    case (rv32i_pkg::load_f3_e'(ex_mem.instr.funct3))
      rv32i_pkg::lb:  load_data = {{24{shifted_rdata[7]}}, shifted_rdata[7:0]};
      rv32i_pkg::lbu: load_data = {24'h0, shifted_rdata[7:0]};
      rv32i_pkg::lh:  load_data = {{16{shifted_rdata[15]}}, shifted_rdata[15:0]};
      rv32i_pkg::lhu: load_data = {16'h0, shifted_rdata[15:0]};
      default:        load_data = dcache_rdata;
    endcase
  end

  // **************************************************
  // MEM/WB and writeback
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb <= '{pc: '0, instr: rv32i_pkg::decode(rv32i_pkg::nop_instr), ctrl: '0,
                  alu: '0, load_data: '0, cmp: 1'b0};
    end else if (!stall) begin
      mem_wb <= '{pc: ex_mem.pc, instr: ex_mem.instr, ctrl: ex_mem.ctrl,
                  alu: ex_mem.alu, load_data: load_data, cmp: ex_mem.cmp};
    end
  end

  assign rf_write.we = mem_wb.ctrl.reg_write;
  assign rf_write.rd = mem_wb.instr.rd;

  always_comb begin
    case (mem_wb.ctrl.wb_sel)
      pipe_pkg::wb_cmp:   rf_write.data = {31'h0, mem_wb.cmp};
      pipe_pkg::wb_u_imm: rf_write.data = mem_wb.instr.u_imm;
      pipe_pkg::wb_load:  rf_write.data = mem_wb.load_data;
      pipe_pkg::wb_pc4:   rf_write.data = mem_wb.pc + 32'd4;
      default:            rf_write.data = mem_wb.alu;
    endcase
  end

  // control words from the decoder never ask for both
  rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(dmem_req.read && dmem_req.write));

  store_has_mbe: assert property (@(posedge clk) disable iff (reset)
    dmem_req.write |-> dmem_req.mbe != '0);

endmodule

// ==== hw/rv32i_pipeline.sv ====
`timescale 1ns/1ps

module rv32i_pipeline #(
  parameter rv32i_pkg::word_t reset_pc = '0
) (
  input  logic                clk,
  input  logic                reset,
  input  rv32i_pkg::word_t    icache_rdata,
  input  logic                icache_resp,
  input  rv32i_pkg::word_t    dcache_rdata,
  input  logic                dcache_resp,
  output logic                icache_read,
  output rv32i_pkg::word_t    icache_address,
  output logic                dcache_read,
  output logic                dcache_write,
  output rv32i_pkg::byte_en_t dcache_mbe,
  output rv32i_pkg::word_t    dcache_address,
  output rv32i_pkg::word_t    dcache_wdata
);

  logic                 stall;
  logic                 mem_busy;
  pipe_pkg::if_id_t     if_id;
  pipe_pkg::ctrl_word_t ctrl;
  rv32i_pkg::word_t     rs1_data;
  rv32i_pkg::word_t     rs2_data;
  pipe_pkg::ex_mem_t    ex_mem;
  pipe_pkg::redirect_t  redirect;
  pipe_pkg::dmem_req_t  dmem_req;
  pipe_pkg::rf_write_t  rf_write;

  // **************************************************
  // stages
  // **************************************************

  fetch_stage #(
    .reset_pc(reset_pc)
  ) i_fetch_stage (
    .clk           (clk),
    .reset         (reset),
    .icache_rdata  (icache_rdata),
    .icache_resp   (icache_resp),
    .mem_busy      (mem_busy),
    .redirect      (redirect),
    .icache_read   (icache_read),
    .icache_address(icache_address),
    .stall         (stall),
    .if_id         (if_id)
  );

  // register read happens in decode, write in writeback
  regfile i_regfile (
    .clk     (clk),
    .reset   (reset),
    .rs1_idx (if_id.instr.rs1),
    .rs2_idx (if_id.instr.rs2),
    .write   (rf_write),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  ctrl_decoder i_ctrl_decoder (
    .instr(if_id.instr),
    .ctrl (ctrl)
  );

  execute_stage i_execute_stage (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .if_id   (if_id),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .ctrl    (ctrl),
    .ex_mem  (ex_mem),
    .redirect(redirect)
  );

  memory_writeback i_memory_writeback (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .ex_mem      (ex_mem),
    .dcache_rdata(dcache_rdata),
    .dcache_resp (dcache_resp),
    .dmem_req    (dmem_req),
    .mem_busy    (mem_busy),
    .rf_write    (rf_write)
  );

  // data request onto the port pins
  assign dcache_read    = dmem_req.read;
  assign dcache_write   = dmem_req.write;
  assign dcache_mbe     = dmem_req.mbe;
  assign dcache_address = dmem_req.address;
  assign dcache_wdata   = dmem_req.wdata;

endmodule

// ==== dv/tb_rv32i_pipeline.sv ====
`timescale 1ns/1ps

module tb_rv32i_pipeline;

  typedef struct packed {
    rv32i_pkg::word_t    addr;
    rv32i_pkg::word_t    data;
    rv32i_pkg::byte_en_t mbe;
  } store_t;

  logic                clk;
  logic                reset;
  rv32i_pkg::word_t    icache_rdata;
  logic                icache_resp;
  rv32i_pkg::word_t    dcache_rdata;
  logic                dcache_resp;
  logic                icache_read;
  rv32i_pkg::word_t    icache_address;
  logic                dcache_read;
  logic                dcache_write;
  rv32i_pkg::byte_en_t dcache_mbe;
  rv32i_pkg::word_t    dcache_address;
  rv32i_pkg::word_t    dcache_wdata;

  rv32i_pkg::word_t imem [1024];
  rv32i_pkg::word_t dmem [512];
  store_t           exp_q [$];
  store_t           wr_q [$];
  logic [31:0]      rng;
  bit               delays_on;
  bit               pending;
  int               dwait;
  int               pc_idx;
  int               test_errs;
  int               passes;
  int               fails;
  int               cycles;
  int               limit;
  bit               running;
  bit               check_busy;
  string            test_name;
  event             check_req;

  rv32i_pipeline #(.reset_pc(32'h0)) i_rv32i_pipeline (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fill value mixes every address bit
  function automatic rv32i_pkg::word_t fill_word(input int idx);
    return (idx * 32'h9e37_79b1) ^ 32'h8080_8080;
  endfunction

  // **************************************************
  // memory models
  // **************************************************

  always @(posedge clk) begin
    #2;
    rng          = lcg_next(rng);
    icache_rdata = imem[icache_address[11:2]];
    icache_resp  = delays_on ? (rng[9:8] != 2'b00) : 1'b1;
    if (reset) begin
      pending     = 0;
      dcache_resp = 1'b0;
    end else if (dcache_read || dcache_write) begin
      if (!pending) begin
        pending = 1;
        dwait   = delays_on ? rng[17:16] % 3 : 0;
      end
      if (dwait == 0) begin
        pending      = 0;
        dcache_resp  = 1'b1;
        dcache_rdata = dmem[dcache_address[10:2]];
        if (dcache_write) begin
          for (int b = 0; b < 4; b++) begin
            if (dcache_mbe[b]) dmem[dcache_address[10:2]][8*b +: 8] = dcache_wdata[8*b +: 8];
          end
          wr_q.push_back('{addr: dcache_address, data: dcache_wdata, mbe: dcache_mbe});
        end
      end else begin
        dcache_resp = 1'b0;
        dwait--;
      end
    end else begin
      pending     = 0;
      dcache_resp = 1'b0;
    end
  end

  // **************************************************
  // encoders and reference model
  // **************************************************

  function automatic rv32i_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv32i_pkg::op_reg};
  endfunction

  function automatic rv32i_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                              logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32i_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32i_pkg::op_br};
  endfunction

  function automatic rv32i_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32i_pkg::op_jal};
  endfunction

  function automatic rv32i_pkg::word_t alu_ref(logic [2:0] f3, bit alt, rv32i_pkg::word_t a,
                                               rv32i_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'h0, $signed(a) < $signed(b)};
      3'd3: return {31'h0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? rv32i_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_ref(logic [2:0] f3, rv32i_pkg::word_t a, rv32i_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic rv32i_pkg::word_t load_ref(logic [2:0] f3, rv32i_pkg::word_t w,
                                                logic [1:0] off);
    rv32i_pkg::word_t s;
    s = w >> (8 * off);
    case (f3)
      3'd0: return {{24{s[7]}}, s[7:0]};
      3'd4: return {24'h0, s[7:0]};
      3'd1: return {{16{s[15]}}, s[15:0]};
      3'd5: return {16'h0, s[15:0]};
      default: return w;
    endcase
  endfunction

  // store as the data port should see it
  function automatic store_t expected_store(rv32i_pkg::word_t addr, rv32i_pkg::word_t value,
                                            logic [2:0] f3);
    store_t r;
    r.addr = {addr[31:2], 2'b00};
    r.data = value << (8 * addr[1:0]);
    r.mbe  = (f3 == 3'd0) ? 4'b0001 << addr[1:0] :
             (f3 == 3'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
    return r;
  endfunction

  // **************************************************
  // program building
  // **************************************************

  task automatic start_program();
    for (int i = 0; i < 1024; i++) imem[i] = rv32i_pkg::nop_instr;
    pc_idx = 0;
    exp_q.delete();
  endtask

  // pad keeps dependents four slots apart
  task automatic emit(input rv32i_pkg::word_t w, input bit pad);
    imem[pc_idx] = w;
    pc_idx += pad ? 4 : 1;
  endtask

  task automatic put_store(input logic [4:0] rs2, input logic [2:0] f3, input logic [11:0] addr,
                           input rv32i_pkg::word_t value, input bit should_store, input bit pad);
    emit({addr[11:5], rs2, 5'd0, f3, addr[4:0], rv32i_pkg::op_store}, pad);
    if (should_store) exp_q.push_back(expected_store({20'h0, addr}, value, f3));
  endtask

  task automatic build_alu();
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    logic [11:0]      slot;
    logic [4:0]       rs2;
    a    = 32'h8765_4321;
    b    = 32'h0012_3fff;
    slot = 12'h400;
    start_program();
    emit({20'h87654, 5'd1, rv32i_pkg::op_lui}, 1);
    emit(i_type(12'h321, 1, 0, 1, rv32i_pkg::op_imm), 1);
    emit({20'h00124, 5'd2, rv32i_pkg::op_lui}, 1);
    emit(i_type(12'hfff, 2, 0, 2, rv32i_pkg::op_imm), 1);
    emit(i_type(12'h007, 0, 0, 3, rv32i_pkg::op_imm), 1);
    for (int f = 0; f < 8; f++) begin
      for (int v = 0; v < 2; v++) begin
        if (v == 0 || f == 0 || f == 5) begin
          rs2 = (f == 1 || f == 5) ? 5'd3 : 5'd2;
          emit(r_type(v ? 7'h20 : 7'h00, rs2, 1, f, 4), 1);
          put_store(4, 3'd2, slot, alu_ref(f, v, a, rs2 == 3 ? 32'd7 : b), 1, 1);
          slot += 4;
        end
      end
    end
    // immediate forms, shifts take a shamt
    for (int f = 0; f < 8; f++) begin
      for (int v = 0; v < 2; v++) begin
        if (v == 0 || f == 5) begin
          if (f == 1 || f == 5) begin
            emit(i_type(v ? 12'h409 : 12'h009, 1, f, 4, rv32i_pkg::op_imm), 1);
            put_store(4, 3'd2, slot, alu_ref(f, v, a, 32'd9), 1, 1);
          end else begin
            emit(i_type(12'hedd, 1, f, 4, rv32i_pkg::op_imm), 1);
            put_store(4, 3'd2, slot, alu_ref(f, 0, a, 32'hffff_fedd), 1, 1);
          end
          slot += 4;
        end
      end
    end
    emit({20'habcde, 5'd4, rv32i_pkg::op_lui}, 1);
    put_store(4, 3'd2, slot, 32'habcd_e000, 1, 1);
    a = pc_idx * 4;
    emit({20'h12345, 5'd4, rv32i_pkg::op_auipc}, 1);
    put_store(4, 3'd2, slot + 4, a + 32'h1234_5000, 1, 1);
    emit(j_type(0, 0), 0);
  endtask

  task automatic build_stores();
    int n;
    n = 0;
    start_program();
    emit({20'hcafeb, 5'd5, rv32i_pkg::op_lui}, 1);
    emit(i_type(12'h0ba, 5, 0, 5, rv32i_pkg::op_imm), 1);
    for (int f = 0; f < 3; f++) begin
      for (int off = 0; off < 4; off += (1 << f)) begin
        put_store(5, f, 12'h500 + 16 * n + off, 32'hcafe_b0ba, 1, 1);
        n++;
      end
    end
    emit(j_type(0, 0), 0);
  endtask

  task automatic build_loads();
    int          n;
    logic [11:0] addr;
    int          codes [5] = '{0, 1, 2, 4, 5};
    n = 0;
    start_program();
    foreach (codes[c]) begin
      for (int off = 0; off < 4; off += (1 << codes[c][1:0])) begin
        addr = 12'h600 + 16 * n + off;
        emit(i_type(addr, 0, codes[c], 6, rv32i_pkg::op_load), 1);
        put_store(6, 3'd2, 12'h700 + 4 * n, load_ref(codes[c], fill_word(addr >> 2), off), 1, 1);
        n++;
      end
    end
    emit(j_type(0, 0), 0);
  endtask

  task automatic build_branches();
    int               n;
    bit               taken;
    rv32i_pkg::word_t p;
    int               codes [6] = '{0, 1, 4, 5, 6, 7};
    n = 0;
    start_program();
    emit(i_type(12'h005, 0, 0, 1, rv32i_pkg::op_imm), 1);
    emit(i_type(12'hffd, 0, 0, 2, rv32i_pkg::op_imm), 1);
    foreach (codes[c]) begin
      for (int same = 0; same < 2; same++) begin
        taken = branch_ref(codes[c], 32'd5, same ? 32'd5 : 32'hffff_fffd);
        emit(b_type(13'd16, same ? 5'd1 : 5'd2, 1, codes[c]), 0);
        // three slots squashed when taken
        for (int k = 0; k < 3; k++) put_store(1, 3'd2, 12'h740 + 16 * n + 4 * k, 5, !taken, 0);
        put_store(1, 3'd2, 12'h74c + 16 * n, 5, 1, 1);
        n++;
      end
    end
    p = pc_idx * 4;
    emit(j_type(21'd16, 10), 0);
    for (int k = 0; k < 3; k++) put_store(1, 3'd2, 12'h410 + 4 * k, 5, 0, 0);
    put_store(10, 3'd2, 12'h400, p + 4, 1, 1);
    p = pc_idx * 4 + 16;
    emit(i_type(p[11:0] + 12'd12, 0, 0, 11, rv32i_pkg::op_imm), 1);
    emit(i_type(12'h004, 11, 0, 12, rv32i_pkg::op_jalr), 0);
    for (int k = 0; k < 3; k++) put_store(1, 3'd2, 12'h420 + 4 * k, 5, 0, 0);
    put_store(12, 3'd2, 12'h404, p + 4, 1, 1);
    emit(j_type(0, 0), 0);
  endtask

  // **************************************************
  // checking
  // **************************************************

  task automatic check_word(input string name, input rv32i_pkg::word_t got,
                            input rv32i_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_mbe(input string name, input rv32i_pkg::byte_en_t got,
                           input rv32i_pkg::byte_en_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      test_errs++;
    end
  endtask

  always @(check_req) begin
    store_t got;
    store_t exp;
    while (exp_q.size() > 0) begin
      got = wr_q.pop_front();
      exp = exp_q.pop_front();
      check_word("dcache_address", got.addr, exp.addr);
      check_word("dcache_wdata", got.data, exp.data);
      check_mbe("dcache_mbe", got.mbe, exp.mbe);
    end
    wr_q.delete();
    check_busy = 0;
  end

  // limit scales with the program length
  always @(posedge clk) begin
    if (running) begin
      cycles++;
      if (cycles > limit) begin
        $display("test %s timed out with %0d of %0d expected stores seen",
                 test_name, wr_q.size(), exp_q.size());
        $display("Verification failed");
        $finish;
      end
    end
  end

  task automatic run_test(input string name);
    test_errs = 0;
    @(posedge clk);
    #2;
    reset = 1'b1;
    repeat (10) @(posedge clk);
    // no fetch and no data request while the stage registers hold bubbles
    check_level("icache_read", icache_read, 1'b0);
    check_level("dcache_read", dcache_read, 1'b0);
    check_level("dcache_write", dcache_write, 1'b0);
    for (int i = 0; i < 512; i++) dmem[i] = fill_word(i);
    wr_q.delete();
    #2;
    reset     = 1'b0;
    test_name = name;
    cycles    = 0;
    limit     = pc_idx * 40;
    running   = 1;
    while (wr_q.size() < exp_q.size()) begin
      @(posedge clk);
      // fetch requests every cycle once out of reset
      check_level("icache_read", icache_read, 1'b1);
    end
    running    = 0;
    check_busy = 1;
    ->check_req;
    wait (!check_busy);
    $display("%s with %s: %s", name, delays_on ? "random delays" : "no delays",
             test_errs == 0 ? "ok" : "mismatch");
    if (test_errs == 0) passes++;
    else fails++;
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    icache_rdata = rv32i_pkg::nop_instr;
    icache_resp  = 1'b0;
    dcache_rdata = '0;
    dcache_resp  = 1'b0;
    rng          = 32'h8391;
    delays_on    = 0;
    pending      = 0;
    dwait        = 0;
    running      = 0;
    passes       = 0;
    fails        = 0;
    // second pass repeats everything with random response delays
    for (int d = 0; d < 2; d++) begin
      delays_on = d;
      build_alu();
      run_test("alu");
      build_stores();
      run_test("stores");
      build_loads();
      run_test("loads");
      build_branches();
      run_test("branches");
    end
    $display("tests passed: %0d, failed: %0d", passes, fails);
    if (fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hw/rv32i_pkg.sv
hw/pipe_pkg.sv
hw/fetch_stage.sv
hw/regfile.sv
hw/ctrl_decoder.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/rv32i_pipeline.sv
dv/tb_rv32i_pipeline.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipeline

sources:
  - files:
      - hw/rv32i_pkg.sv
      - hw/pipe_pkg.sv
      - hw/fetch_stage.sv
      - hw/regfile.sv
      - hw/ctrl_decoder.sv
      - hw/execute_stage.sv
      - hw/memory_writeback.sv
      - hw/rv32i_pipeline.sv
  - target: test
    files:
      - dv/tb_rv32i_pipeline.sv
